//--- source/usb_tx_pkg.sv
`default_nettype none

package usb_tx_pkg;

  // field widths
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;

  // upper nibble is the complement of the lower one
  typedef enum logic [7:0] {
    PID_OUT   = 8'hE1,
    PID_IN    = 8'h69,
    PID_DATA0 = 8'hC3,
    PID_DATA1 = 8'h4B,
    PID_ACK   = 8'hD2,
    PID_NAK   = 8'h5A
  } usb_pid_e;

  // taken straight from pid[1:0]
  typedef enum logic [1:0] {
    KIND_TOKEN     = 2'b01,
    KIND_HANDSHAKE = 2'b10,
    KIND_DATA      = 2'b11
  } pkt_kind_e;

  // request fields other than the payload
  typedef struct packed {
    usb_pid_e  pid;
    usb_addr_t addr;
    usb_endp_t endp;
  } usb_token_t;

  // one serial bit between encoder, stuffer and nrzi
  typedef struct packed {
    logic data;
    logic valid;
    logic stuff_en;
    logic last;
  } tx_bit_t;

  // sent lsb first, so seven zeros then a one
  localparam logic [7:0] SYNC_PATTERN = 8'b1000_0000;

  localparam logic [4:0]  CRC5_POLY  = 5'h05;
  localparam logic [15:0] CRC16_POLY = 16'h8005;

  localparam int unsigned STUFF_RUN = 6;

endpackage : usb_tx_pkg

`default_nettype wire

//--- source/crc_generator.sv
`timescale 1ns/10ps
`default_nettype none

module crc_generator #(
  parameter int unsigned      WIDTH = 5,
  parameter logic [WIDTH-1:0] POLY  = 5'h05
) (
  input  logic clk,
  input  logic rst_L,
  input  logic en,
  input  logic clear,
  input  logic msg_bit,
  input  logic send_rem,
  output logic crc_bit
);

  logic [WIDTH-1:0] crc_q;
  logic             feedback;

  assign feedback = crc_q[WIDTH-1] ^ msg_bit;

  // message bits go straight through, remainder goes out inverted
  assign crc_bit = send_rem ? ~crc_q[WIDTH-1] : msg_bit;

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      crc_q <= '1;
    end else if (clear) begin
      crc_q <= '1;
    end else if (en) begin
      if (send_rem) begin
        // shift the remainder out msb first
        crc_q <= {crc_q[WIDTH-2:0], 1'b1};
      end else if (feedback) begin
        crc_q <= {crc_q[WIDTH-2:0], 1'b0} ^ POLY;
      end else begin
        crc_q <= {crc_q[WIDTH-2:0], 1'b0};
      end
    end
  end

endmodule : crc_generator

`default_nettype wire

//--- source/bit_stuffer.sv
`timescale 1ns/10ps
`default_nettype none

module bit_stuffer
  import usb_tx_pkg::*;
(
  input  logic    clk,
  input  logic    rst_L,
  input  tx_bit_t in_bit,
  output tx_bit_t out_bit,
  output logic    stall
);

  localparam int unsigned RUN_W = $clog2(STUFF_RUN + 1);

  logic [RUN_W-1:0] ones_cnt;

  // a full run is only broken up if another bit follows it
  assign stall = in_bit.valid && (ones_cnt == RUN_W'(STUFF_RUN));

  always_comb begin
    out_bit = in_bit;
    if (stall) begin
      // inserted zero, the held bit keeps its last flag
      out_bit.data     = 1'b0;
      out_bit.valid    = 1'b1;
      out_bit.stuff_en = 1'b1;
      out_bit.last     = 1'b0;
    end
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      ones_cnt <= '0;
    end else if (stall) begin
      ones_cnt <= '0;
    end else if (in_bit.valid) begin
      if (in_bit.last || !in_bit.stuff_en || !in_bit.data)
        ones_cnt <= '0;
      else
        ones_cnt <= ones_cnt + 1'b1;
    end
  end

endmodule : bit_stuffer

`default_nettype wire

//--- source/nrzi_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module nrzi_encoder
  import usb_tx_pkg::*;
(
  input  logic    clk,
  input  logic    rst_L,
  input  tx_bit_t in_bit,
  output tx_bit_t out_bit
);

  // line level, 1 is J
  logic level_q;
  logic coded;

  // zero toggles, one holds
  assign coded = in_bit.data ? level_q : ~level_q;

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      level_q <= 1'b1;
      out_bit <= '0;
    end else begin
      out_bit.data     <= in_bit.valid ? coded : level_q;
      out_bit.valid    <= in_bit.valid;
      out_bit.stuff_en <= in_bit.stuff_en;
      out_bit.last     <= in_bit.valid && in_bit.last;
      if (in_bit.valid) begin
        // next packet starts from idle J again
        level_q <= in_bit.last ? 1'b1 : coded;
      end
    end
  end

endmodule : nrzi_encoder

`default_nettype wire

//--- source/line_driver.sv
`timescale 1ns/10ps
`default_nettype none

module line_driver
  import usb_tx_pkg::*;
(
  input  logic    clk,
  input  logic    rst_L,
  input  tx_bit_t in_bit,
  output logic    line_en,
  output logic    dp,
  output logic    dm,
  output logic    eop_done
);

  typedef enum logic [2:0] {
    IDLE, PACKET, EOP_SE0_A, EOP_SE0_B, EOP_J
  } drv_state_e;

  drv_state_e state;
  logic       bit_q;
  logic       last_q;

  always_ff @(posedge clk) begin
    if (in_bit.valid)
      bit_q <= in_bit.data;
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state  <= IDLE;
      last_q <= 1'b0;
    end else begin
      if (in_bit.valid)
        last_q <= in_bit.last;
      case (state)
        IDLE: begin
          if (in_bit.valid)
            state <= PACKET;
        end
        PACKET: begin
          if (last_q)
            state <= EOP_SE0_A;
        end
        EOP_SE0_A: state <= EOP_SE0_B;
        EOP_SE0_B: state <= EOP_J;
        default:   state <= IDLE;
      endcase
    end
  end

  // line levels follow the state directly
  always_comb begin
    line_en = 1'b1;
    dp      = 1'b0;
    dm      = 1'b0;
    case (state)
      IDLE:   line_en = 1'b0;
      PACKET: begin
        dp = bit_q;
        dm = ~bit_q;
      end
      // single ended zero on both EOP_SE0 states
      EOP_SE0_A, EOP_SE0_B: begin
        dp = 1'b0;
        dm = 1'b0;
      end
      default: dp = 1'b1;
    endcase
  end

  // encoder leaves WAIT_EOP as the J ends
  assign eop_done = (state == EOP_J);

endmodule : line_driver

`default_nettype wire

//--- source/packet_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module packet_encoder
  import usb_tx_pkg::*;
#(
  parameter int unsigned DATA_BYTES = 8
) (
  input  logic                    clk,
  input  logic                    rst_L,
  input  logic                    pkt_start,
  input  usb_token_t              token,
  input  logic [DATA_BYTES*8-1:0] payload,
  input  logic                    stall,
  input  logic                    eop_done,
  output tx_bit_t                 enc_bit,
  output logic                    busy
);

  localparam int unsigned DATA_BITS = DATA_BYTES * 8;
  // counter must also cover the 16 crc bits
  localparam int unsigned CNT_W = $clog2(DATA_BITS > 16 ? DATA_BITS : 16);

  typedef enum logic [3:0] {
    IDLE, SYNC, PID, ADDR, ENDP, CRC5, DATA, CRC16, WAIT_EOP
  } enc_state_e;

  enc_state_e             state;
  enc_state_e             next_state;
  logic [CNT_W-1:0]       bit_cnt;
  logic [CNT_W-1:0]       field_last;
  logic                   field_done;
  logic                   accept;
  usb_token_t             tok_q;
  logic [DATA_BITS-1:0]   data_q;
  pkt_kind_e              kind;
  logic                   crc5_msg;
  logic                   crc5_bit;
  logic                   crc16_bit;

  assign accept     = pkt_start && (state == IDLE);
  assign busy       = (state != IDLE);
  assign kind       = pkt_kind_e'(tok_q.pid[1:0]);
  assign field_done = (bit_cnt == field_last);

  // request fields, sampled only on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      tok_q  <= token;
      data_q <= payload;
    end
  end

  assign crc5_msg = (state == ADDR) ? tok_q.addr[bit_cnt[2:0]] : tok_q.endp[bit_cnt[1:0]];

  crc_generator #(
    .WIDTH(5),
    .POLY (CRC5_POLY)
  ) u_crc5 (
    .clk     (clk),
    .rst_L   (rst_L),
    .en      (!stall && (state inside {ADDR, ENDP, CRC5})),
    .clear   (accept),
    .msg_bit (crc5_msg),
    .send_rem(state == CRC5),
    .crc_bit (crc5_bit)
  );

  crc_generator #(
    .WIDTH(16),
    .POLY (CRC16_POLY)
  ) u_crc16 (
    .clk     (clk),
    .rst_L   (rst_L),
    .en      (!stall && (state inside {DATA, CRC16})),
    .clear   (accept),
    .msg_bit (data_q[bit_cnt]),
    .send_rem(state == CRC16),
    .crc_bit (crc16_bit)
  );

  // bit mux, field length and follow-on state
  always_comb begin
    enc_bit    = '0;
    field_last = '0;
    next_state = WAIT_EOP;
    case (state)
      SYNC: begin
        enc_bit.data  = SYNC_PATTERN[bit_cnt[2:0]];
        enc_bit.valid = 1'b1;
        field_last    = CNT_W'(7);
        next_state    = PID;
      end
      PID: begin
        enc_bit.data     = tok_q.pid[bit_cnt[2:0]];
        enc_bit.valid    = 1'b1;
        enc_bit.stuff_en = 1'b1;
        field_last       = CNT_W'(7);
        case (kind)
          KIND_TOKEN: next_state = ADDR;
          KIND_DATA:  next_state = DATA;
          // handshake is pid only
          default:    enc_bit.last = (bit_cnt == CNT_W'(7));
        endcase
      end
      ADDR, ENDP, CRC5: begin
        enc_bit.data     = crc5_bit;
        enc_bit.valid    = 1'b1;
        enc_bit.stuff_en = 1'b1;
        if (state == ADDR) begin
          field_last = CNT_W'(6);
          next_state = ENDP;
        end else if (state == ENDP) begin
          field_last = CNT_W'(3);
          next_state = CRC5;
        end else begin
          field_last   = CNT_W'(4);
          enc_bit.last = (bit_cnt == CNT_W'(4));
        end
      end
      DATA, CRC16: begin
        enc_bit.data     = crc16_bit;
        enc_bit.valid    = 1'b1;
        enc_bit.stuff_en = 1'b1;
        if (state == DATA) begin
          field_last = CNT_W'(DATA_BITS - 1);
          next_state = CRC16;
        end else begin
          field_last   = CNT_W'(15);
          enc_bit.last = (bit_cnt == CNT_W'(15));
        end
      end
      default: begin
        enc_bit = '0;
      end
    endcase
  end

  // a stall from the stuffer freezes everything
  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else if (!stall) begin
      case (state)
        IDLE: begin
          bit_cnt <= '0;
          if (accept)
            state <= SYNC;
        end
        WAIT_EOP: begin
          if (eop_done)
            state <= IDLE;
        end
        default: begin
          if (field_done) begin
            bit_cnt <= '0;
            state   <= next_state;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule : packet_encoder

`default_nettype wire

//--- source/usb_host_tx.sv
`timescale 1ns/10ps
`default_nettype none

module usb_host_tx
  import usb_tx_pkg::*;
#(
  parameter int unsigned DATA_BYTES = 8
) (
  input  logic                    clk,
  input  logic                    rst_L,
  input  logic                    pkt_start,
  input  usb_token_t              token,
  input  logic [DATA_BYTES*8-1:0] payload,
  output logic                    busy,
  output logic                    line_en,
  output logic                    dp,
  output logic                    dm
);

  tx_bit_t enc_bit;
  tx_bit_t stuffed_bit;
  tx_bit_t line_bit;
  logic    stall;
  logic    eop_done;

  packet_encoder #(
    .DATA_BYTES(DATA_BYTES)
  ) u_encoder (
    .clk      (clk),
    .rst_L    (rst_L),
    .pkt_start(pkt_start),
    .token    (token),
    .payload  (payload),
    .stall    (stall),
    .eop_done (eop_done),
    .enc_bit  (enc_bit),
    .busy     (busy)
  );

  bit_stuffer u_stuffer (
    .clk    (clk),
    .rst_L  (rst_L),
    .in_bit (enc_bit),
    .out_bit(stuffed_bit),
    .stall  (stall)
  );

  nrzi_encoder u_nrzi (
    .clk    (clk),
    .rst_L  (rst_L),
    .in_bit (stuffed_bit),
    .out_bit(line_bit)
  );

  line_driver u_driver (
    .clk     (clk),
    .rst_L   (rst_L),
    .in_bit  (line_bit),
    .line_en (line_en),
    .dp      (dp),
    .dm      (dm),
    .eop_done(eop_done)
  );

endmodule : usb_host_tx

`default_nettype wire

//--- bench/tb_usb_host_tx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_usb_host_tx
  import usb_tx_pkg::*;
();

  localparam int unsigned DATA_BYTES = 8;
  localparam int unsigned DATA_BITS  = DATA_BYTES * 8;
  // sync, pid, payload and crc16 is the longest packet
  localparam int unsigned MAX_BITS   = 32 + DATA_BITS;
  localparam int unsigned RAW_MAX    = MAX_BITS + MAX_BITS / 6 + 8;
  localparam int unsigned IDLE_GAP   = 10;
  localparam int unsigned TIMEOUT_CYCLES = 40 * 200 + 100;

  logic                 clk;
  logic                 rst_L;
  logic                 pkt_start;
  usb_token_t           token;
  logic [DATA_BITS-1:0] payload;
  logic                 busy;
  logic                 line_en;
  logic                 dp;
  logic                 dm;

  logic [MAX_BITS-1:0]  exp_vec = '0;
  int                   exp_len = 0;
  string                cur_name = "reset";
  int                   packets_sent = 0;
  int                   packets_seen = 0;
  int                   cycle_cnt = 0;
  logic [31:0]          rng_state = 32'ha756_e898;
  logic                 raw_dp [0:RAW_MAX-1];
  logic                 raw_dm [0:RAW_MAX-1];
  int                   raw_n = 0;
  logic                 prev_en = 1'b0;

  usb_host_tx #(
    .DATA_BYTES(DATA_BYTES)
  ) UUT (
    .clk      (clk),
    .rst_L    (rst_L),
    .pkt_start(pkt_start),
    .token    (token),
    .payload  (payload),
    .busy     (busy),
    .line_en  (line_en),
    .dp       (dp),
    .dm       (dm)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [MAX_BITS-1:0] expected,
                             input logic [MAX_BITS-1:0] actual);
    if (expected !== actual)
      report_failure($sformatf("ERROR %s %s: expected %h actual %h",
                               cur_name, what, expected, actual));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int expected_len(input usb_pid_e pid);
    case (pid)
      PID_OUT, PID_IN:     return 32;
      PID_DATA0, PID_DATA1: return 32 + DATA_BITS;
      default:             return 16;
    endcase
  endfunction

  // unstuffed bit string in wire order with bit 0 sent first
  function automatic logic [MAX_BITS-1:0] expected_bits(input usb_token_t tok,
                                                        input logic [DATA_BITS-1:0] data);
    logic [MAX_BITS-1:0] v;
    logic [10:0]         tok_bits;
    logic [4:0]          crc5;
    logic [15:0]         crc16;
    logic                fb;
    int                  n;
    v        = '0;
    n        = 0;
    tok_bits = {tok.endp, tok.addr};
    crc5     = '1;
    crc16    = '1;
    for (int i = 0; i < 8; i++) begin
      v[n] = (i == 7);
      n++;
    end
    for (int i = 0; i < 8; i++) begin
      v[n] = tok.pid[i];
      n++;
    end
    if (tok.pid == PID_OUT || tok.pid == PID_IN) begin
      // crc5 covers addr then endp
      for (int i = 0; i < 11; i++) begin
        v[n] = tok_bits[i];
        n++;
        fb   = crc5[4] ^ tok_bits[i];
        crc5 = {crc5[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
      end
      for (int i = 4; i >= 0; i--) begin
        v[n] = ~crc5[i];
        n++;
      end
    end else if (tok.pid == PID_DATA0 || tok.pid == PID_DATA1) begin
      for (int i = 0; i < DATA_BITS; i++) begin
        v[n]  = data[i];
        n++;
        fb    = crc16[15] ^ data[i];
        crc16 = {crc16[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
      for (int i = 15; i >= 0; i--) begin
        v[n] = ~crc16[i];
        n++;
      end
    end
    return v;
  endfunction

  // zeros the transmitter inserts when another bit follows six ones
  function automatic int stuff_count(input logic [MAX_BITS-1:0] v, input int len);
    int ones;
    int stuffs;
    ones   = 0;
    stuffs = 0;
    for (int i = 8; i < len; i++) begin
      if (ones == 6) begin
        stuffs++;
        ones = 0;
      end
      ones = v[i] ? ones + 1 : 0;
    end
    return stuffs;
  endfunction

  // nrzi decode from J, drop stuffed zeros, then compare with the reference
  task automatic decode_packet();
    logic [MAX_BITS-1:0] got;
    int                  got_len;
    int                  ones;
    int                  stuffs;
    logic                level;
    logic                b;
    got     = '0;
    got_len = 0;
    ones    = 0;
    stuffs  = 0;
    level   = 1'b1;
    if (raw_n < 11)
      report_failure("line was driven too briefly to hold a packet");
    check_value("eop", 6'b00_00_10, {raw_dp[raw_n-3], raw_dm[raw_n-3], raw_dp[raw_n-2],
                                     raw_dm[raw_n-2], raw_dp[raw_n-1], raw_dm[raw_n-1]});
    for (int i = 0; i < raw_n - 3; i++) begin
      check_value("dm level", !raw_dp[i], raw_dm[i]);
      b     = (raw_dp[i] == level);
      level = raw_dp[i];
      if (i >= 8 && ones == 6) begin
        check_value("stuffed bit", 1'b0, b);
        stuffs++;
        ones = 0;
      end else if (got_len >= MAX_BITS) begin
        report_failure("decoded packet is longer than any valid packet");
      end else begin
        got[got_len] = b;
        got_len++;
        if (i >= 8)
          ones = b ? ones + 1 : 0;
      end
    end
    packets_seen++;
    check_value("length", exp_len, got_len);
    check_value("bits", exp_vec, got);
    check_value("stuff count", stuff_count(exp_vec, exp_len), stuffs);
  endtask

  // line monitor samples on the falling edge
  always @(negedge clk) begin
    if (rst_L) begin
      if (line_en && !busy)
        report_failure("line_en was still high after busy fell");
      if (line_en) begin
        if (raw_n >= RAW_MAX)
          report_failure("line stayed driven longer than any packet");
        raw_dp[raw_n] = dp;
        raw_dm[raw_n] = dm;
        raw_n++;
      end else if (prev_en) begin
        decode_packet();
        raw_n = 0;
      end
      prev_en = line_en;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_failure($sformatf("timeout after %0d cycles, the DUT did not finish", cycle_cnt));
  end

  task automatic random_token(input usb_pid_e pid, output usb_token_t t);
    rng_state = xorshift32(rng_state);
    t.pid  = pid;
    t.addr = rng_state[6:0];
    t.endp = rng_state[11:8];
  endtask

  task automatic random_payload(output logic [DATA_BITS-1:0] d);
    for (int i = 0; i < DATA_BYTES; i++) begin
      rng_state    = xorshift32(rng_state);
      d[i*8 +: 8] = rng_state[7:0];
    end
  endtask

  task automatic send_packet(input string name, input usb_token_t tok,
                             input logic [DATA_BITS-1:0] data, input bit pulse_while_busy);
    cur_name = name;
    exp_vec  = expected_bits(tok, data);
    exp_len  = expected_len(tok.pid);
    @(posedge clk);
    #1;
    token     = tok;
    payload   = data;
    pkt_start = 1'b1;
    packets_sent++;
    @(posedge clk);
    #1;
    pkt_start = 1'b0;
    if (!busy)
      report_failure("busy did not rise after pkt_start");
    if (pulse_while_busy) begin
      repeat (4) @(posedge clk);
      #1;
      // a different request that must be ignored
      token.pid  = PID_DATA0;
      token.addr = ~tok.addr;
      token.endp = ~tok.endp;
      payload    = ~data;
      pkt_start  = 1'b1;
      @(posedge clk);
      #1;
      pkt_start = 1'b0;
    end
    while (busy) begin
      @(posedge clk);
      #1;
    end
    repeat (IDLE_GAP) @(posedge clk);
    #1;
    check_value("packet count", packets_sent, packets_seen);
    check_value("idle line", 3'b000, {line_en, dp, dm});
  endtask

  initial begin
    usb_token_t           tok;
    logic [DATA_BITS-1:0] data;
    rst_L     = 1'b0;
    pkt_start = 1'b0;
    token     = '0;
    payload   = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_L = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_value("outputs", 4'b0000, {busy, line_en, dp, dm});
    end

    for (int i = 0; i < 8; i++) begin
      random_token((i % 2) ? PID_IN : PID_OUT, tok);
      send_packet((i % 2) ? "in token" : "out token", tok, '0, 1'b0);
    end

    for (int i = 0; i < 8; i++) begin
      random_token((i % 2) ? PID_DATA1 : PID_DATA0, tok);
      random_payload(data);
      send_packet((i % 2) ? "data1 random" : "data0 random", tok, data, 1'b0);
    end

    // long runs of ones force stuffing all through the payload
    random_token(PID_DATA0, tok);
    send_packet("data0 all ones", tok, '1, 1'b0);
    random_token(PID_DATA1, tok);
    send_packet("data1 all ones", tok, '1, 1'b0);

    random_token(PID_ACK, tok);
    send_packet("ack", tok, '0, 1'b0);
    random_token(PID_NAK, tok);
    send_packet("nak", tok, '0, 1'b0);

    random_token(PID_OUT, tok);
    send_packet("start while busy token", tok, '0, 1'b1);
    random_token(PID_DATA1, tok);
    random_payload(data);
    send_packet("start while busy data", tok, data, 1'b1);

    $display("Simulation passed");
    $finish;
  end

endmodule : tb_usb_host_tx

`default_nettype wire

//--- src.f
source/usb_tx_pkg.sv
source/crc_generator.sv
source/bit_stuffer.sv
source/nrzi_encoder.sv
source/line_driver.sv
source/packet_encoder.sv
source/usb_host_tx.sv
bench/tb_usb_host_tx.sv
